// File: hw/mmc3_chr_map.sv
/* MMC3 CHR address translation and nametable A10 / chip enable */
`default_nettype none

module mmc3_chr_map (
	input  wire  [13:0]           chr_addr_i, // PPU A13..A0
	input  mmc3_pkg::map_state_t  state_i,
	output mmc3_pkg::mem_addr_t   chr_addr_o,
	output logic                  vram_a10_o,
	output logic                  vram_ce_o
);

	logic                            half_hi; // 1 KB bank half selected
	logic [mmc3_pkg::CHR_BANK_W-1:0] chr_bank; // Final 1 KB bank
	logic [2:0]                      fine_idx; // R2..R5

	assign half_hi  = chr_addr_i[12] ^ state_i.chr_invert;
	assign fine_idx = {1'b0, chr_addr_i[11:10]} + 3'd2;

	always_comb begin
		if (!half_hi) begin
			// 2 KB bank, A10 picks the 1 KB half
			chr_bank = {state_i.chr_bank[chr_addr_i[11]][mmc3_pkg::CHR_BANK_W-2:0],
				chr_addr_i[10]};
		end else begin
			chr_bank = state_i.chr_bank[fine_idx];
		end
	end

	assign chr_addr_o = {mmc3_pkg::CHR_ROM_BASE, chr_bank, chr_addr_i[9:0]};

	// Horizontal mirroring pairs nametables by A11
	assign vram_a10_o = state_i.mirror_horiz ? chr_addr_i[11] : chr_addr_i[10];
	assign vram_ce_o  = chr_addr_i[13]; // $2000 and up is CIRAM

endmodule

`default_nettype wire

// File: hw/mmc3_pkg.sv
/* MMC3 shared types and constants: CPU bus, register select enum,
   mapping state and IRQ command structs */
`default_nettype none

package mmc3_pkg;

	localparam int PRG_BANK_W = 6;  // 8 KB PRG bank number
	localparam int CHR_BANK_W = 8;  // 1 KB CHR bank number
	localparam int MEM_ADDR_W = 22; // Flat cartridge memory space

	// Upper address bits that place each region in the flat space
	localparam logic [8:0] PRG_RAM_BASE = 9'b111100000; // PRG RAM at the top
	localparam logic [3:0] CHR_ROM_BASE = 4'b1000;      // CHR ROM above PRG ROM

	localparam logic [PRG_BANK_W-1:0] PRG_LAST_BANK        = 6'd63; // Fixed at $E000
	localparam logic [PRG_BANK_W-1:0] PRG_SECOND_LAST_BANK = 6'd62; // Fixed at $8000/$C000

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	// CPU side access, qualified externally by the M2 enable
	typedef struct packed {
		logic [15:0] addr;  // CPU A15..A0
		logic [7:0]  data;  // Write data
		logic        write; // Write strobe
	} cpu_bus_t;

	// Register selected by {A14, A13, A0} within $8000-$FFFF
	typedef enum logic [2:0] {
		REG_BANK_SELECT = 3'b000, // $8000 even
		REG_BANK_DATA   = 3'b001, // $8001 odd
		REG_MIRRORING   = 3'b010, // $A000 even
		REG_RAM_PROTECT = 3'b011, // $A001 odd
		REG_IRQ_LATCH   = 3'b100, // $C000 even
		REG_IRQ_RELOAD  = 3'b101, // $C001 odd
		REG_IRQ_DISABLE = 3'b110, // $E000 even
		REG_IRQ_ENABLE  = 3'b111  // $E001 odd
	} mmc3_reg_e;

	// Registered banking state seen by both address translators
	typedef struct packed {
		logic prg_mode;     // Swaps $8000 and $C000 windows
		logic chr_invert;   // Swaps the 2 KB and 1 KB halves
		logic mirror_horiz; // 1 selects horizontal mirroring
		logic ram_enable;   // PRG RAM chip enable
		logic ram_protect;  // PRG RAM write protect
		logic [1:0][PRG_BANK_W-1:0] prg_bank; // R6, R7
		// R0..R5; R0 and R1 keep the 2 KB number, data bits 7..1
		logic [5:0][CHR_BANK_W-1:0] chr_bank;
	} map_state_t;

	// One-clk command pulses to the scanline counter
	typedef struct packed {
		logic       latch_wr;    // $C000 write
		logic       reload;      // $C001 write
		logic       disable_irq; // $E000 write
		logic       enable;      // $E001 write
		logic [7:0] data;        // Latch value
	} irq_cmd_t;

endpackage

`default_nettype wire

// File: hw/mmc3_prg_map.sv
/* MMC3 PRG address translation: 8 KB ROM windows, PRG RAM window,
   access allow */
`default_nettype none

module mmc3_prg_map (
	input  mmc3_pkg::cpu_bus_t    cpu_i,
	input  mmc3_pkg::map_state_t  state_i,
	output mmc3_pkg::mem_addr_t   prg_addr_o,
	output logic                  prg_allow_o
);

	logic [mmc3_pkg::PRG_BANK_W-1:0] prg_bank; // Bank for the current window
	logic                            ram_win;  // $6000-$7FFF
	logic                            ram_ok;   // Permitted RAM access

	// Window select from A14..A13 and mode
	always_comb begin
		case ({cpu_i.addr[14:13], state_i.prg_mode})
			3'b00_0: prg_bank = state_i.prg_bank[0];              // $8000 R6
			3'b00_1: prg_bank = mmc3_pkg::PRG_SECOND_LAST_BANK;   // $8000 fixed
			3'b01_0,
			3'b01_1: prg_bank = state_i.prg_bank[1];              // $A000 R7
			3'b10_0: prg_bank = mmc3_pkg::PRG_SECOND_LAST_BANK;   // $C000 fixed
			3'b10_1: prg_bank = state_i.prg_bank[0];              // $C000 R6
			default: prg_bank = mmc3_pkg::PRG_LAST_BANK;          // $E000 always last
		endcase
	end

	assign ram_win = (cpu_i.addr[15:13] == 3'b011);
	assign ram_ok  = ram_win && state_i.ram_enable
		&& !(state_i.ram_protect && cpu_i.write); // Protect blocks writes only

	// RAM sits at the top of the flat space, ROM at the bottom
	assign prg_addr_o = ram_ok ? {mmc3_pkg::PRG_RAM_BASE, cpu_i.addr[12:0]}
		: {3'b000, prg_bank, cpu_i.addr[12:0]};

	// ROM is read only
	assign prg_allow_o = (cpu_i.addr[15] && !cpu_i.write) || ram_ok;

endmodule

`default_nettype wire

// File: hw/mmc3_reg_file.sv
/* MMC3 register file: CPU write decode, bank and mode registers,
   IRQ command pulse generation */
`default_nettype none

module mmc3_reg_file (
	input  wire                   clk,
	input  wire                   rst_n_i,
	input  wire                   ce_i,      // M2 enable
	input  mmc3_pkg::cpu_bus_t    cpu_i,
	output mmc3_pkg::map_state_t  state_o,
	output mmc3_pkg::irq_cmd_t    irq_cmd_o
);

	mmc3_pkg::map_state_t state_q; // Banking and mode state
	logic [2:0]           bank_idx_q; // Target of next bank data write
	logic                 wr_en;      // Qualified write to $8000-$FFFF
	mmc3_pkg::mmc3_reg_e  reg_sel;    // Decoded register

	assign wr_en   = ce_i && cpu_i.write && cpu_i.addr[15];
	assign reg_sel = mmc3_pkg::mmc3_reg_e'({cpu_i.addr[14:13], cpu_i.addr[0]});

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q    <= '0; // All banks 0, RAM off
			bank_idx_q <= 3'd0;
		end else if (wr_en) begin
			case (reg_sel)
				mmc3_pkg::REG_BANK_SELECT: begin
					state_q.chr_invert <= cpu_i.data[7];
					state_q.prg_mode   <= cpu_i.data[6];
					bank_idx_q         <= cpu_i.data[2:0];
				end
				mmc3_pkg::REG_BANK_DATA: begin
					case (bank_idx_q)
						// 2 KB banks ignore data bit 0
						3'd0, 3'd1: state_q.chr_bank[bank_idx_q] <= {1'b0, cpu_i.data[7:1]};
						3'd2, 3'd3, 3'd4, 3'd5: state_q.chr_bank[bank_idx_q] <= cpu_i.data;
						3'd6: state_q.prg_bank[0] <= cpu_i.data[mmc3_pkg::PRG_BANK_W-1:0];
						3'd7: state_q.prg_bank[1] <= cpu_i.data[mmc3_pkg::PRG_BANK_W-1:0];
						default: ;
					endcase
				end
				mmc3_pkg::REG_MIRRORING: begin
					state_q.mirror_horiz <= cpu_i.data[0]; // 0 vertical, 1 horizontal
				end
				mmc3_pkg::REG_RAM_PROTECT: begin
					state_q.ram_enable  <= cpu_i.data[7];
					state_q.ram_protect <= cpu_i.data[6];
				end
				default: ; // IRQ registers live in the counter block
			endcase
		end
	end

	assign state_o = state_q;

	// Command pulses, one clk wide since wr_en needs ce_i
	always_comb begin
		irq_cmd_o             = '0;
		irq_cmd_o.data        = cpu_i.data;
		irq_cmd_o.latch_wr    = wr_en && (reg_sel == mmc3_pkg::REG_IRQ_LATCH);
		irq_cmd_o.reload      = wr_en && (reg_sel == mmc3_pkg::REG_IRQ_RELOAD);
		irq_cmd_o.disable_irq = wr_en && (reg_sel == mmc3_pkg::REG_IRQ_DISABLE);
		irq_cmd_o.enable      = wr_en && (reg_sel == mmc3_pkg::REG_IRQ_ENABLE);
	end

endmodule

`default_nettype wire

// File: hw/mmc3_scanline_irq.sv
/* MMC3 scanline IRQ: A12 rise filter, down-counter with latch and
   reload, IRQ enable and line */
`default_nettype none

module mmc3_scanline_irq #(
	parameter bit          ALT_IRQ    = 1'b0, // 1 selects MMC3A "alternate" zero behaviour
	parameter int unsigned A12_FILTER = 15    // Low ce cycles before A12 counts again, >= 1
) (
	input  wire                 clk,
	input  wire                 rst_n_i,
	input  wire                 ce_i,      // M2 enable
	input  wire                 chr_a12_i, // PPU A12
	input  mmc3_pkg::irq_cmd_t  irq_cmd_i,
	output logic                irq_o
);

	localparam int FILT_W = $clog2(A12_FILTER + 1);

	logic [FILT_W-1:0] filt_q;     // Cool-down after A12 high
	logic [7:0]        counter_q;  // Scanline down-counter
	logic [7:0]        latch_q;    // Reload value
	logic              reload_q;   // Reload pending
	logic              irq_en_q;   // IRQ enable
	logic              irq_q;
	logic              a12_edge;   // Counted A12 rise
	logic [7:0]        next_cnt;
	logic              irq_set;

	assign a12_edge = ce_i && chr_a12_i && (filt_q == '0);
	assign next_cnt = ((counter_q == 8'd0) || reload_q) ? latch_q : counter_q - 8'd1;

	// Normal flavour fires at zero, alternate only on a transition to zero
	assign irq_set = a12_edge && (next_cnt == 8'd0) && irq_en_q
		&& (!ALT_IRQ || (counter_q != 8'd0) || reload_q);

	// A12 filter
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			filt_q <= '0;
		end else if (ce_i) begin
			if (chr_a12_i) begin
				filt_q <= FILT_W'(A12_FILTER); // Restart cool-down
			end else if (filt_q != '0) begin
				filt_q <= filt_q - FILT_W'(1);
			end
		end
	end

	// Counter, latch and reload flag
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			counter_q <= 8'd0;
			latch_q   <= 8'd0;
			reload_q  <= 1'b0;
		end else begin
			if (irq_cmd_i.latch_wr) begin
				latch_q <= irq_cmd_i.data;
			end
			if (irq_cmd_i.reload) begin
				reload_q <= 1'b1;
			end
			if (a12_edge) begin
				counter_q <= next_cnt;
				reload_q  <= 1'b0; // Edge wins over same-cycle reload write
			end
		end
	end

	// Enable bit and IRQ line
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			irq_en_q <= 1'b0;
			irq_q    <= 1'b0;
		end else begin
			if (irq_cmd_i.enable) begin
				irq_en_q <= 1'b1;
			end
			if (irq_set) begin
				irq_q <= 1'b1;
			end
			if (irq_cmd_i.disable_irq) begin
				irq_en_q <= 1'b0; // Also acknowledges
				irq_q    <= 1'b0;
			end
		end
	end

	assign irq_o = irq_q;

endmodule

`default_nettype wire

// File: hw/mmc3_top.sv
/* MMC3 mapper top: register file, PRG and CHR translators,
   scanline IRQ */
`default_nettype none

module mmc3_top #(
	parameter bit          ALT_IRQ    = 1'b0, // IRQ zero behaviour flavour
	parameter int unsigned A12_FILTER = 15    // A12 low cycles to rearm
) (
	input  wire                  clk,
	input  wire                  rst_n_i,
	input  wire                  ce_i,       // M2 enable
	input  mmc3_pkg::cpu_bus_t   cpu_i,
	input  wire  [13:0]          chr_addr_i, // PPU address
	output mmc3_pkg::mem_addr_t  prg_addr_o,
	output logic                 prg_allow_o,
	output mmc3_pkg::mem_addr_t  chr_addr_o,
	output logic                 vram_a10_o,
	output logic                 vram_ce_o,
	output logic                 irq_o
);

	mmc3_pkg::map_state_t map_state; // Registered banking state
	mmc3_pkg::irq_cmd_t   irq_cmd;   // Decoded IRQ writes

	mmc3_reg_file u_reg_file (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.ce_i      (ce_i),
		.cpu_i     (cpu_i),
		.state_o   (map_state),
		.irq_cmd_o (irq_cmd)
	);

	mmc3_prg_map u_prg_map (
		.cpu_i       (cpu_i),
		.state_i     (map_state),
		.prg_addr_o  (prg_addr_o),
		.prg_allow_o (prg_allow_o)
	);

	mmc3_chr_map u_chr_map (
		.chr_addr_i (chr_addr_i),
		.state_i    (map_state),
		.chr_addr_o (chr_addr_o),
		.vram_a10_o (vram_a10_o),
		.vram_ce_o  (vram_ce_o)
	);

	mmc3_scanline_irq #(
		.ALT_IRQ    (ALT_IRQ),
		.A12_FILTER (A12_FILTER)
	) u_scanline_irq (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.ce_i      (ce_i),
		.chr_a12_i (chr_addr_i[12]), // Raw A12, filtered inside
		.irq_cmd_i (irq_cmd),
		.irq_o     (irq_o)
	);

endmodule

`default_nettype wire

// File: list.f
+incdir+tests
hw/mmc3_pkg.sv
hw/mmc3_reg_file.sv
hw/mmc3_prg_map.sv
hw/mmc3_chr_map.sv
hw/mmc3_scanline_irq.sv
hw/mmc3_top.sv
tests/tb_mmc3.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the MMC3 testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir
TOP=tb_mmc3

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module "$TOP" -Mdir "$BUILD" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

"./$BUILD/$TOP" | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Finished with errors" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi
if ! grep -qx "Finished with no errors" "$LOG"; then
	echo "Simulation ended without a result line, see $LOG"
	exit 1
fi
exit 0

// File: tests/tb_mmc3_tasks.svh
/* Testbench helpers: input stepping, CPU writes and probes, A12 pulses,
   expected PRG/CHR address models, checks and error counters */
`ifndef TB_MMC3_TASKS_SVH
`define TB_MMC3_TASKS_SVH

int err_count   = 0; // Failed checks
int check_count = 0; // All checks
int test_count  = 0; // Finished tests

// One clk; inputs move 1 unit after the rising edge
task automatic step();
	@(posedge clk);
	#1;
	ce = ~ce; // M2 enable every other clk
endtask

// Land in a cycle that carries ce
task automatic step_to_ce();
	step();
	if (!ce) begin
		step();
	end
endtask

// Qualified CPU write, taken at the edge that ends the ce cycle
task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
	step_to_ce();
	cpu.addr  = addr;
	cpu.data  = data;
	cpu.write = 1'b1;
	step(); // State updated here
	cpu.write = 1'b0;
endtask

// Bank select with mode bits, then bank data
task automatic write_bank(input logic [2:0] idx, input logic [7:0] val,
	input logic inv, input logic mode);
	cpu_write(16'h8000, {inv, mode, 3'b000, idx});
	cpu_write(16'h8001, val);
endtask

// Present a CPU access and let the combinational outputs settle
task automatic cpu_probe(input logic [15:0] addr, input logic wr);
	step();
	cpu.addr  = addr;
	cpu.write = wr;
	#2;
endtask

task automatic ppu_probe(input logic [13:0] addr);
	step();
	chr_addr = addr;
	#2; // Settle
endtask

// A12 high for one ce cycle; returns one clk after the edge
task automatic a12_pulse();
	step_to_ce();
	chr_addr = 14'h1000;
	step();
	chr_addr = 14'h0000;
endtask

task automatic a12_idle(input int ce_cycles);
	repeat (2 * ce_cycles) step(); // A12 stays low
endtask

// Window rule: mode swaps $8000 and $C000, $E000 is always the last bank
function automatic mmc3_pkg::mem_addr_t expected_prg_addr(input logic [15:0] addr,
	input logic mode, input logic [5:0] r6, input logic [5:0] r7);
	logic [5:0] bank;
	case (addr[14:13])
		2'd0: bank = mode ? mmc3_pkg::PRG_SECOND_LAST_BANK : r6;
		2'd1: bank = r7;
		2'd2: bank = mode ? r6 : mmc3_pkg::PRG_SECOND_LAST_BANK;
		default: bank = mmc3_pkg::PRG_LAST_BANK;
	endcase
	return {3'b000, bank, addr[12:0]};
endfunction

// Low half uses 2 KB banks R0/R1, high half 1 KB banks R2..R5
function automatic mmc3_pkg::mem_addr_t expected_chr_addr(input logic [13:0] a,
	input logic inv, input logic [5:0][7:0] regs);
	logic [7:0] bank;
	if (a[12] == inv) begin
		bank = {regs[{2'b00, a[11]}][7:1], a[10]}; // Data bit 0 dropped
	end else begin
		bank = regs[3'd2 + {1'b0, a[11:10]}];
	end
	return {4'b1000, bank, a[9:0]};
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	check_count++;
	assert (actual === expected) else begin
		$display("** Error: %s expected %h got %h at %0t", name, expected, actual, $time);
		err_count++;
	end
endtask

task automatic finish_test(input string name, input int errs_before);
	test_count++;
	$display("test %0d %s: %0d errors", test_count, name, err_count - errs_before);
endtask

`endif

// File: tests/tb_mmc3.sv
/* MMC3 mapper testbench: clock, reset, DUT, watchdog,
   directed and random test sequence, closing report */
`default_nettype none

module tb_mmc3;

	localparam int A12_FILTER = 15;
	localparam int A12_GAP    = A12_FILTER + 1; // Low ce cycles to rearm the filter
	localparam int NUM_TESTS  = 7;
	localparam int LONGEST_TEST_CYCLES = 400;  // IRQ count test, N = 5
	localparam int TIMEOUT = 2 * NUM_TESTS * LONGEST_TEST_CYCLES * 8;
	localparam logic [31:0] SEED = 32'h0f75_c63a;

	logic                clk = 1'b0;
	logic                rst_n;
	logic                ce;           // M2 enable
	mmc3_pkg::cpu_bus_t  cpu;
	logic [13:0]         chr_addr;     // PPU address
	mmc3_pkg::mem_addr_t prg_addr;
	logic                prg_allow;
	mmc3_pkg::mem_addr_t chr_addr_out;
	logic                vram_a10;
	logic                vram_ce;
	logic                irq;

	always #4 clk = ~clk;

	mmc3_top #(
		.ALT_IRQ    (1'b0),
		.A12_FILTER (A12_FILTER)
	) u_mmc3_top (
		.clk         (clk),
		.rst_n_i     (rst_n),
		.ce_i        (ce),
		.cpu_i       (cpu),
		.chr_addr_i  (chr_addr),
		.prg_addr_o  (prg_addr),
		.prg_allow_o (prg_allow),
		.chr_addr_o  (chr_addr_out),
		.vram_a10_o  (vram_a10),
		.vram_ce_o   (vram_ce),
		.irq_o       (irq)
	);

	`include "tb_mmc3_tasks.svh"

	task automatic reset_state();
		int          errs;
		logic [12:0] low;
		errs = err_count;
		low  = 13'($urandom());
		check_value("irq_o", 32'(1'b0), 32'(irq));
		cpu_probe({3'b100, low}, 1'b0); // $8000 window, R6 = 0
		check_value("prg_addr_o", 32'({3'b000, 6'd0, low}), 32'(prg_addr));
		cpu_probe({3'b110, low}, 1'b0);
		check_value("prg_addr_o", 32'({3'b000, 6'd62, low}), 32'(prg_addr));
		cpu_probe({3'b111, low}, 1'b0);
		check_value("prg_addr_o", 32'({3'b000, 6'd63, low}), 32'(prg_addr));
		finish_test("reset_state", errs);
	endtask

	task automatic prg_banking();
		int          errs;
		int          m;
		int          w;
		logic [7:0]  r6;
		logic [7:0]  r7;
		logic [15:0] a;
		errs = err_count;
		r6   = 8'($urandom());
		r7   = 8'($urandom());
		for (m = 0; m < 2; m++) begin
			write_bank(3'd6, r6, 1'b0, m[0]);
			write_bank(3'd7, r7, 1'b0, m[0]);
			for (w = 0; w < 4; w++) begin
				a = {1'b1, w[1:0], 13'($urandom())};
				cpu_probe(a, 1'b0);
				check_value("prg_addr_o", 32'(expected_prg_addr(a, m[0], r6[5:0], r7[5:0])),
					32'(prg_addr));
				check_value("prg_allow_o", 32'(1'b1), 32'(prg_allow));
			end
		end
		finish_test("prg_banking", errs);
	endtask

	task automatic chr_banking();
		int               errs;
		int               inv;
		int               i;
		logic [5:0][7:0]  regs;
		logic [13:0]      a;
		errs = err_count;
		for (i = 0; i < 6; i++) begin
			regs[i] = 8'($urandom());
		end
		for (inv = 0; inv < 2; inv++) begin
			for (i = 0; i < 6; i++) begin
				write_bank(3'(i), regs[i], inv[0], 1'b0);
			end
			for (i = 0; i < 16; i++) begin
				a = {1'b0, 13'($urandom())}; // Pattern table space
				ppu_probe(a);
				check_value("chr_addr_o", 32'(expected_chr_addr(a, inv[0], regs)),
					32'(chr_addr_out));
			end
		end
		write_bank(3'd0, regs[0], 1'b0, 1'b0); // Invert back off
		finish_test("chr_banking", errs);
	endtask

	task automatic mirroring();
		int          errs;
		int          h;
		int          i;
		logic [13:0] a;
		errs = err_count;
		for (h = 0; h < 2; h++) begin
			cpu_write(16'hA000, {7'd0, h[0]}); // 0 vertical, 1 horizontal
			for (i = 0; i < 8; i++) begin
				a = 14'($urandom());
				ppu_probe(a);
				check_value("vram_a10_o", 32'(h[0] ? a[11] : a[10]), 32'(vram_a10));
				check_value("vram_ce_o", 32'(a[13]), 32'(vram_ce));
			end
		end
		finish_test("mirroring", errs);
	endtask

	task automatic prg_ram();
		int          errs;
		logic [12:0] low;
		errs = err_count;
		low  = 13'($urandom());
		cpu_probe({3'b011, low}, 1'b0);
		check_value("prg_allow_o", 32'(1'b0), 32'(prg_allow)); // RAM still disabled
		cpu_write(16'hA001, 8'h80);
		cpu_probe({3'b011, low}, 1'b0);
		check_value("prg_allow_o", 32'(1'b1), 32'(prg_allow));
		check_value("prg_addr_o", 32'({mmc3_pkg::PRG_RAM_BASE, low}), 32'(prg_addr));
		cpu_probe({3'b011, low}, 1'b1);
		check_value("prg_allow_o", 32'(1'b1), 32'(prg_allow)); // Unprotected write
		cpu_write(16'hA001, 8'hC0);
		cpu_probe({3'b011, low}, 1'b1);
		check_value("prg_allow_o", 32'(1'b0), 32'(prg_allow)); // Protected write
		cpu_probe({3'b011, low}, 1'b0);
		check_value("prg_allow_o", 32'(1'b1), 32'(prg_allow));
		check_value("prg_addr_o", 32'({mmc3_pkg::PRG_RAM_BASE, low}), 32'(prg_addr));
		cpu_write(16'hA001, 8'h00);
		finish_test("prg_ram", errs);
	endtask

	task automatic irq_counting();
		int errs;
		int n;
		int i;
		errs     = err_count;
		n        = int'($urandom_range(5, 1));
		chr_addr = 14'h0000;
		a12_idle(A12_GAP); // Drain the filter
		cpu_write(16'hC000, 8'(n));
		cpu_write(16'hC001, 8'h00);
		cpu_write(16'hE001, 8'h00);
		for (i = 1; i <= n + 1; i++) begin
			a12_pulse(); // First pulse loads N
			check_value("irq_o", 32'(i == n + 1), 32'(irq));
			a12_idle(A12_GAP);
		end
		check_value("irq_o", 32'(1'b1), 32'(irq)); // Held until disable
		cpu_write(16'hE000, 8'h00);
		check_value("irq_o", 32'(1'b0), 32'(irq));
		finish_test("irq_counting", errs);
	endtask

	task automatic irq_filter();
		int errs;
		errs = err_count;
		cpu_write(16'hC000, 8'h01);
		cpu_write(16'hC001, 8'h00);
		cpu_write(16'hE001, 8'h00);
		a12_idle(A12_GAP);
		a12_pulse(); // Reload to 1
		check_value("irq_o", 32'(1'b0), 32'(irq));
		a12_idle(4);
		a12_pulse(); // Inside the filter window
		check_value("irq_o", 32'(1'b0), 32'(irq));
		a12_idle(A12_GAP);
		a12_pulse(); // 1 -> 0
		check_value("irq_o", 32'(1'b1), 32'(irq));
		cpu_write(16'hE000, 8'h00);
		finish_test("irq_filter", errs);
	endtask

	// Watchdog sized from the test count and the longest test
	initial begin
		#(TIMEOUT);
		$display("Watchdog timeout: test sequence did not complete");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		ce       = 1'b0;
		rst_n    = 1'b0;
		cpu      = '0;
		chr_addr = 14'h0000;
		repeat (4) step(); // Reset over 4 edges
		rst_n = 1'b1;
		step();
		reset_state();
		prg_banking();
		chr_banking();
		mirroring();
		prg_ram();
		irq_counting();
		irq_filter();
		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire
